// ==== verilog/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// slot array size
`define CACHE_SLOTS       16

// page geometry, one page is 256 words of 32 bits
`define PAGE_WORDS_LOG2   8
`define PAGE_BITS         15
`define HOST_ADDR_BITS    23   // host word address
`define MEM_ADDR_BITS     24   // controller port halfword address

// life policy
`define LIFE_BITS         16
`define LIFE_FILL         512  // life of a freshly filled page
`define LIFE_BONUS        32   // added on every read hit

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

  // request as presented by the host bus
  typedef struct packed {
    logic                        read;
    logic                        write;
    logic [`HOST_ADDR_BITS-1:0]  addr;
    logic [31:0]                 wdata;
    logic [3:0]                  byte_en;
  } host_req_t;

  // single word access from the controller to the sequencer
  typedef struct packed {
    logic                        write;
    logic [`HOST_ADDR_BITS-1:0]  addr;
    logic [31:0]                 wdata;
    logic [3:0]                  wmask;    // 1 masks the byte off
  } word_req_t;

  // per-slot state seen by the victim pick
  typedef struct packed {
    logic                        valid;
    logic                        dirty;
    logic                        free;     // life has run out
    logic [`PAGE_BITS-1:0]       page;
  } slot_status_t;

endpackage

// ==== verilog/cache_slot.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_slot (
  input  logic                         clk,
  input  logic                         sys_rst_n,
  input  logic [`PAGE_BITS-1:0]        req_page,
  input  logic [`PAGE_WORDS_LOG2-1:0]  word_index,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   byte_en,
  input  logic                         write_en,
  input  logic                         selected,
  input  logic                         set_page,
  input  logic                         set_dirty,
  input  logic                         clear,
  input  logic                         adj_life,
  output logic [31:0]                  rdata,
  output logic                         hit,
  output cache_pkg::slot_status_t      status
);

  logic [31:0]             page_ram [0:(1 << `PAGE_WORDS_LOG2)-1];
  logic                    valid;
  logic                    dirty;
  logic [`PAGE_BITS-1:0]   tag;
  logic [`LIFE_BITS-1:0]   life;

  // byte-enabled page RAM, registered read
  always_ff @(posedge clk) begin
    if (write_en && selected) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) page_ram[word_index][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
    rdata <= page_ram[word_index];
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      valid <= 1'b0;
      dirty <= 1'b0;
      tag   <= '0;
      life  <= '0;
    end else if (clear) begin      // flush done
      valid <= 1'b0;
      dirty <= 1'b0;
      life  <= '0;
    end else begin
      if (set_page) begin
        tag   <= req_page;
        valid <= 1'b1;
        dirty <= 1'b0;             // old contents already written back
        life  <= `LIFE_BITS'(`LIFE_FILL);
      end else if (adj_life) begin
        if (selected) begin
          if (!life[`LIFE_BITS-1]) life <= life + `LIFE_BITS'(`LIFE_BONUS);
        end else if (life != '0) begin
          life <= life - 1'b1;     // decay toward free
        end
      end
      if (set_dirty) dirty <= 1'b1;
    end
  end

  assign hit    = valid && (tag == req_page);
  assign status = '{valid: valid, dirty: dirty, free: (life == '0), page: tag};

  a_set_clear_excl: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(set_page && clear));

endmodule

// ==== verilog/slot_select.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module slot_select (
  input  logic [`CACHE_SLOTS-1:0]   hit_vec,
  input  cache_pkg::slot_status_t   status_vec [`CACHE_SLOTS],
  input  logic [31:0]               rdata_vec [`CACHE_SLOTS],
  input  logic [`CACHE_SLOTS-1:0]   current_slot,
  output logic [`CACHE_SLOTS-1:0]   victim,
  output logic                      victim_dirty,
  output logic [31:0]               hit_data,
  output logic [31:0]               current_data,
  output logic [`PAGE_BITS-1:0]     current_page
);

  // lowest free slot wins as the scan runs from the top
  always_comb begin
    victim = '0;
    for (int i = `CACHE_SLOTS-1; i >= 0; i--) begin
      if (status_vec[i].free) begin
        victim    = '0;
        victim[i] = 1'b1;
      end
    end
  end

  // one-hot and-or muxes
  always_comb begin
    victim_dirty = 1'b0;
    hit_data     = '0;
    current_data = '0;
    current_page = '0;
    for (int i = 0; i < `CACHE_SLOTS; i++) begin
      victim_dirty = victim_dirty | (victim[i] & status_vec[i].dirty);
      hit_data     = hit_data | (rdata_vec[i] & {32{hit_vec[i]}});
      current_data = current_data | (rdata_vec[i] & {32{current_slot[i]}});
      current_page = current_page | (status_vec[i].page & {`PAGE_BITS{current_slot[i]}});
    end
  end

  // tags must stay unique across slots
  always_comb begin
    a_hit_onehot: assert final ($onehot0(hit_vec));
  end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
  input  logic                         clk,
  input  logic                         sys_rst_n,
  input  cache_pkg::host_req_t         host,
  input  logic                         flush_valid,
  input  logic [`PAGE_BITS-1:0]        flush_page,
  input  logic [`CACHE_SLOTS-1:0]      hit_vec,
  input  logic [`CACHE_SLOTS-1:0]      victim,
  input  logic                         victim_dirty,
  input  logic [31:0]                  hit_data,
  input  logic [31:0]                  current_data,
  input  logic [`PAGE_BITS-1:0]        current_page,
  input  logic                         word_done,
  input  logic [31:0]                  word_rdata,
  output logic [31:0]                  readdata,
  output logic                         waitrequest,
  output logic [`CACHE_SLOTS-1:0]      current_slot,
  output logic [`PAGE_WORDS_LOG2-1:0]  word_index,
  output logic [31:0]                  slot_wdata,
  output logic [3:0]                   slot_byte_en,
  output logic                         write_en,
  output logic [`CACHE_SLOTS-1:0]      set_page_vec,
  output logic [`CACHE_SLOTS-1:0]      set_dirty_vec,
  output logic [`CACHE_SLOTS-1:0]      clear_vec,
  output logic                         adj_life,
  output logic                         word_go,
  output cache_pkg::word_req_t         word_req
);

  typedef enum logic [2:0] {
    S_IDLE, S_FILL, S_FILL_DLY, S_WBACK, S_FLUSH, S_UNC_RD, S_UNC_WR
  } state_t;

  state_t                    state;
  logic [`PAGE_WORDS_LOG2:0] cnt;         // word counter over one page
  logic                      advance;     // bump cnt after a finished word
  logic                      dly;
  logic                      ack;
  logic                      hit_hold;    // RAM data of a read hit is on hit_data
  logic [31:0]               readdata_q;
  logic [`PAGE_BITS-1:0]     req_page;
  logic [`PAGE_BITS-1:0]     page_sel;
  logic                      flush_hit;
  logic                      page_state;
  logic                      page_done;

  assign req_page    = host.addr[`HOST_ADDR_BITS-1:`PAGE_WORDS_LOG2];
  assign flush_hit   = flush_valid && (flush_page == req_page);
  assign page_state  = state inside {S_FILL, S_WBACK, S_FLUSH};
  assign page_done   = cnt[`PAGE_WORDS_LOG2];
  assign word_index  = page_state ? cnt[`PAGE_WORDS_LOG2-1:0]
                                  : host.addr[`PAGE_WORDS_LOG2-1:0];
  assign waitrequest = (host.read || host.write) && !ack;
  assign readdata    = hit_hold ? hit_data : readdata_q;
  assign page_sel    = (state == S_FILL) ? req_page : current_page;

  always_comb begin
    word_req.write = state inside {S_WBACK, S_FLUSH, S_UNC_WR};
    word_req.addr  = (state inside {S_UNC_RD, S_UNC_WR}) ? host.addr
                                                         : {page_sel, cnt[`PAGE_WORDS_LOG2-1:0]};
    word_req.wdata = (state == S_UNC_WR) ? host.wdata : current_data;
    word_req.wmask = (state == S_UNC_WR) ? ~host.byte_en : 4'b0000;
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state         <= S_IDLE;
      cnt           <= '0;
      advance       <= 1'b0;
      dly           <= 1'b0;
      ack           <= 1'b0;
      hit_hold      <= 1'b0;
      readdata_q    <= '0;
      current_slot  <= '0;
      slot_wdata    <= '0;
      slot_byte_en  <= '0;
      write_en      <= 1'b0;
      set_page_vec  <= '0;
      set_dirty_vec <= '0;
      clear_vec     <= '0;
      adj_life      <= 1'b0;
      word_go       <= 1'b0;
    end else begin
      write_en      <= 1'b0;      // strobes last one cycle
      adj_life      <= 1'b0;
      set_page_vec  <= '0;
      set_dirty_vec <= '0;
      clear_vec     <= '0;
      if (!host.read && !host.write) ack <= 1'b0;
      if (hit_hold) begin
        readdata_q <= hit_data;
        hit_hold   <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if ((host.read || host.write) && !ack) begin
            if (host.read && |hit_vec) begin
              current_slot <= hit_vec;
              if (flush_hit) begin
                cnt   <= '0;
                state <= S_FLUSH;   // whole page goes back, then invalidate
              end else begin
                adj_life <= 1'b1;
                hit_hold <= 1'b1;
                ack      <= 1'b1;
              end
            end else if (host.read && |victim) begin
              current_slot <= victim;
              cnt          <= '0;
              if (victim_dirty) begin
                state <= S_WBACK;
              end else begin
                set_page_vec <= victim;
                state        <= S_FILL;
              end
            end else if (host.read) begin
              current_slot <= '0;   // no slot selected, all lives decay
              state        <= S_UNC_RD;
            end else if (|hit_vec) begin
              current_slot  <= hit_vec;
              slot_wdata    <= host.wdata;
              slot_byte_en  <= host.byte_en;
              write_en      <= 1'b1;
              set_dirty_vec <= hit_vec;
              ack           <= 1'b1;
            end else begin
              state <= S_UNC_WR;    // write miss, no allocation
            end
          end
        end
        S_FILL, S_WBACK, S_FLUSH: begin
          if (word_go && word_done) begin
            word_go <= 1'b0;
            advance <= 1'b1;
            if (state == S_FILL) begin
              slot_wdata   <= word_rdata;
              slot_byte_en <= 4'b1111;
              write_en     <= 1'b1;
            end
          end else if (advance) begin
            cnt     <= cnt + 1'b1;  // RAM write uses the old count
            advance <= 1'b0;
          end else if (!word_go && !word_done) begin
            if (!page_done) begin
              word_go <= 1'b1;
            end else if (state == S_FILL) begin
              dly   <= 1'b0;
              state <= S_FILL_DLY;
            end else if (state == S_WBACK) begin
              set_page_vec <= current_slot;
              cnt          <= '0;
              state        <= S_FILL;
            end else begin
              clear_vec <= current_slot;
              ack       <= 1'b1;
              state     <= S_IDLE;
            end
          end
        end
        S_FILL_DLY: begin           // index back on host offset, wait out RAM latency
          if (dly) begin
            readdata_q <= current_data;
            ack        <= 1'b1;
            state      <= S_IDLE;
          end else begin
            dly <= 1'b1;
          end
        end
        S_UNC_RD, S_UNC_WR: begin
          if (word_go && word_done) begin
            word_go <= 1'b0;
            ack     <= 1'b1;
            state   <= S_IDLE;
            if (state == S_UNC_RD) begin
              readdata_q <= word_rdata;
              adj_life   <= 1'b1;
            end
          end else if (!word_go && !word_done) begin
            word_go <= 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  a_slot_onehot: assert property (@(posedge clk) disable iff (!sys_rst_n)
    $onehot0(current_slot));

endmodule

// ==== verilog/mem_sequencer.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_sequencer (
  input  logic                        clk,
  input  logic                        sys_rst_n,
  input  logic                        word_go,
  input  cache_pkg::word_req_t        word_req,
  output logic                        word_done,
  output logic [31:0]                 word_rdata,
  output logic [`MEM_ADDR_BITS-1:0]   mem_addr,
  output logic                        mem_rd_req,
  output logic                        mem_wr_req,
  output logic [15:0]                 mem_din,
  output logic [1:0]                  mem_mask,
  input  logic                        mem_rd_ack,
  input  logic                        mem_wr_ack,
  input  logic [15:0]                 mem_dout
);

  logic [1:0] step;   // 0 idle, 1 wait ack, 2 second beat, 3 hold done

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      step       <= 2'd0;
      word_done  <= 1'b0;
      word_rdata <= '0;
      mem_addr   <= '0;
      mem_rd_req <= 1'b0;
      mem_wr_req <= 1'b0;
      mem_din    <= '0;
      mem_mask   <= '0;
    end else begin
      case (step)
        2'd0: if (word_go) begin
          mem_addr <= {word_req.addr, 1'b0};   // even halfword first
          if (word_req.write) begin
            mem_din    <= word_req.wdata[15:0];
            mem_mask   <= word_req.wmask[1:0];
            mem_wr_req <= 1'b1;
          end else begin
            mem_rd_req <= 1'b1;
          end
          step <= 2'd1;
        end
        2'd1: begin                            // port may stall here
          if (mem_rd_ack) begin
            word_rdata[15:0] <= mem_dout;
            step             <= 2'd2;
          end else if (mem_wr_ack) begin
            mem_din  <= word_req.wdata[31:16];
            mem_mask <= word_req.wmask[3:2];
            step     <= 2'd2;
          end
        end
        2'd2: begin
          if (mem_rd_req) word_rdata[31:16] <= mem_dout;
          mem_rd_req <= 1'b0;
          mem_wr_req <= 1'b0;
          word_done  <= 1'b1;
          step       <= 2'd3;
        end
        default: if (!word_go) begin
          word_done <= 1'b0;
          step      <= 2'd0;
        end
      endcase
    end
  end

  // the port only acknowledges a request that is still held
  a_ack_with_req: assert property (@(posedge clk) disable iff (!sys_rst_n)
    !(mem_rd_ack && !mem_rd_req) && !(mem_wr_ack && !mem_wr_req));

endmodule

// ==== verilog/page_cache_top.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module page_cache_top (
  input  logic                        clk,
  input  logic                        sys_rst_n,
  input  cache_pkg::host_req_t        host,
  output logic [31:0]                 readdata,
  output logic                        waitrequest,
  input  logic                        flush_valid,
  input  logic [`PAGE_BITS-1:0]       flush_page,
  output logic [`MEM_ADDR_BITS-1:0]   mem_addr,
  output logic                        mem_rd_req,
  output logic                        mem_wr_req,
  output logic [15:0]                 mem_din,
  output logic [1:0]                  mem_mask,
  input  logic                        mem_rd_ack,
  input  logic                        mem_wr_ack,
  input  logic [15:0]                 mem_dout
);

  logic [`CACHE_SLOTS-1:0]       hit_vec;
  cache_pkg::slot_status_t       status_vec [`CACHE_SLOTS];
  logic [31:0]                   rdata_vec [`CACHE_SLOTS];
  logic [`CACHE_SLOTS-1:0]       current_slot;
  logic [`CACHE_SLOTS-1:0]       victim;
  logic                          victim_dirty;
  logic [31:0]                   hit_data;
  logic [31:0]                   current_data;
  logic [`PAGE_BITS-1:0]         current_page;
  logic [`PAGE_WORDS_LOG2-1:0]   word_index;
  logic [31:0]                   slot_wdata;
  logic [3:0]                    slot_byte_en;
  logic                          write_en;
  logic [`CACHE_SLOTS-1:0]       set_page_vec;
  logic [`CACHE_SLOTS-1:0]       set_dirty_vec;
  logic [`CACHE_SLOTS-1:0]       clear_vec;
  logic                          adj_life;
  logic                          word_go;
  cache_pkg::word_req_t          word_req;
  logic                          word_done;
  logic [31:0]                   word_rdata;

  for (genvar i = 0; i < `CACHE_SLOTS; i++) begin : g_slot
    cache_slot i_cache_slot (
      .clk        (clk),
      .sys_rst_n  (sys_rst_n),
      .req_page   (host.addr[`HOST_ADDR_BITS-1:`PAGE_WORDS_LOG2]),
      .word_index (word_index),
      .wdata      (slot_wdata),
      .byte_en    (slot_byte_en),
      .write_en   (write_en),
      .selected   (current_slot[i]),
      .set_page   (set_page_vec[i]),
      .set_dirty  (set_dirty_vec[i]),
      .clear      (clear_vec[i]),
      .adj_life   (adj_life),
      .rdata      (rdata_vec[i]),
      .hit        (hit_vec[i]),
      .status     (status_vec[i])
    );
  end

  slot_select i_slot_select (
    .hit_vec      (hit_vec),
    .status_vec   (status_vec),
    .rdata_vec    (rdata_vec),
    .current_slot (current_slot),
    .victim       (victim),
    .victim_dirty (victim_dirty),
    .hit_data     (hit_data),
    .current_data (current_data),
    .current_page (current_page)
  );

  cache_ctrl i_cache_ctrl (
    .clk           (clk),
    .sys_rst_n     (sys_rst_n),
    .host          (host),
    .flush_valid   (flush_valid),
    .flush_page    (flush_page),
    .hit_vec       (hit_vec),
    .victim        (victim),
    .victim_dirty  (victim_dirty),
    .hit_data      (hit_data),
    .current_data  (current_data),
    .current_page  (current_page),
    .word_done     (word_done),
    .word_rdata    (word_rdata),
    .readdata      (readdata),
    .waitrequest   (waitrequest),
    .current_slot  (current_slot),
    .word_index    (word_index),
    .slot_wdata    (slot_wdata),
    .slot_byte_en  (slot_byte_en),
    .write_en      (write_en),
    .set_page_vec  (set_page_vec),
    .set_dirty_vec (set_dirty_vec),
    .clear_vec     (clear_vec),
    .adj_life      (adj_life),
    .word_go       (word_go),
    .word_req      (word_req)
  );

  mem_sequencer i_mem_sequencer (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .word_go    (word_go),
    .word_req   (word_req),
    .word_done  (word_done),
    .word_rdata (word_rdata),
    .mem_addr   (mem_addr),
    .mem_rd_req (mem_rd_req),
    .mem_wr_req (mem_wr_req),
    .mem_din    (mem_din),
    .mem_mask   (mem_mask),
    .mem_rd_ack (mem_rd_ack),
    .mem_wr_ack (mem_wr_ack),
    .mem_dout   (mem_dout)
  );

endmodule

// ==== sim/sdram_model.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module sdram_model #(
  parameter int ACK_DELAY = 3,      // stall cycles before each acknowledge
  parameter int ADDR_BITS = 17      // halfwords actually backed by storage
) (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  logic [`MEM_ADDR_BITS-1:0]  mem_addr,
  input  logic                       mem_rd_req,
  input  logic                       mem_wr_req,
  input  logic [15:0]                mem_din,
  input  logic [1:0]                 mem_mask,
  output logic                       mem_rd_ack,
  output logic                       mem_wr_ack,
  output logic [15:0]                mem_dout
);

  typedef enum logic [1:0] {M_IDLE, M_SECOND, M_WR_HIGH, M_DROP} phase_t;

  logic [15:0]           mem [0:(1 << ADDR_BITS)-1];
  phase_t                phase;
  logic [ADDR_BITS-1:0]  base;      // even halfword of the burst
  logic                  rd_burst;
  int                    stall;

  // a set mask bit keeps the old byte
  function automatic logic [15:0] masked_half(input logic [15:0] old_half,
                                              input logic [15:0] new_half,
                                              input logic [1:0]  mask);
    masked_half[7:0]  = mask[0] ? old_half[7:0]  : new_half[7:0];
    masked_half[15:8] = mask[1] ? old_half[15:8] : new_half[15:8];
  endfunction

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      phase      <= M_IDLE;
      base       <= '0;
      rd_burst   <= 1'b0;
      stall      <= 0;
      mem_rd_ack <= 1'b0;
      mem_wr_ack <= 1'b0;
      mem_dout   <= '0;
    end else begin
      mem_rd_ack <= 1'b0;
      mem_wr_ack <= 1'b0;
      case (phase)
        M_IDLE: begin
          if (mem_rd_req || mem_wr_req) begin
            if (stall < ACK_DELAY) begin
              stall <= stall + 1;                 // controller busy
            end else begin
              stall    <= 0;
              base     <= mem_addr[ADDR_BITS-1:0];
              rd_burst <= mem_rd_req;
              phase    <= M_SECOND;
              if (mem_rd_req) begin
                mem_rd_ack <= 1'b1;
                mem_dout   <= mem[mem_addr[ADDR_BITS-1:0]];
              end else begin
                mem_wr_ack <= 1'b1;
                mem[mem_addr[ADDR_BITS-1:0]] <=
                  masked_half(mem[mem_addr[ADDR_BITS-1:0]], mem_din, mem_mask);
              end
            end
          end
        end
        M_SECOND: begin
          if (rd_burst) begin
            mem_dout <= mem[base + 1'b1];         // high half follows the ack
            phase    <= M_DROP;
          end else begin
            phase <= M_WR_HIGH;
          end
        end
        M_WR_HIGH: begin                          // high half now on mem_din
          mem[base + 1'b1] <= masked_half(mem[base + 1'b1], mem_din, mem_mask);
          phase            <= M_DROP;
        end
        default: if (!mem_rd_req && !mem_wr_req) phase <= M_IDLE;
      endcase
    end
  end

endmodule

// ==== sim/tb_page_cache.sv ====
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_page_cache;

  localparam int ACK_DELAY       = 3;
  localparam int MODEL_ADDR_BITS = 17;
  localparam int SHADOW_WORDS    = 1 << (MODEL_ADDR_BITS - 1);
  localparam int PAGE_WORDS      = 1 << `PAGE_WORDS_LOG2;
  localparam int PAGE_OPS        = 20;    // fills, flush and write-back
  localparam int UNCACHED_OPS    = 600;
  localparam int WORD_BUDGET     = 4 * (ACK_DELAY + 10);
  localparam int WATCHDOG_CYCLES = (PAGE_OPS * PAGE_WORDS + UNCACHED_OPS) * WORD_BUDGET;

  logic                        clk;
  logic                        sys_rst_n;
  cache_pkg::host_req_t        host;
  logic [31:0]                 readdata;
  logic                        waitrequest;
  logic                        flush_valid;
  logic [`PAGE_BITS-1:0]       flush_page;
  logic [`MEM_ADDR_BITS-1:0]   mem_addr;
  logic                        mem_rd_req;
  logic                        mem_wr_req;
  logic [15:0]                 mem_din;
  logic [1:0]                  mem_mask;
  logic                        mem_rd_ack;
  logic                        mem_wr_ack;
  logic [15:0]                 mem_dout;

  logic [31:0]                 shadow [SHADOW_WORDS];   // expected memory contents
  logic [15:0]                 dirty_idx [$];           // cached words not yet in memory
  logic [31:0]                 dirty_data [$];
  integer                      seed;

  page_cache_top i_page_cache_top (
    .clk         (clk),
    .sys_rst_n   (sys_rst_n),
    .host        (host),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .flush_valid (flush_valid),
    .flush_page  (flush_page),
    .mem_addr    (mem_addr),
    .mem_rd_req  (mem_rd_req),
    .mem_wr_req  (mem_wr_req),
    .mem_din     (mem_din),
    .mem_mask    (mem_mask),
    .mem_rd_ack  (mem_rd_ack),
    .mem_wr_ack  (mem_wr_ack),
    .mem_dout    (mem_dout)
  );

  sdram_model #(.ACK_DELAY(ACK_DELAY), .ADDR_BITS(MODEL_ADDR_BITS)) i_sdram_model (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .mem_addr   (mem_addr),
    .mem_rd_req (mem_rd_req),
    .mem_wr_req (mem_wr_req),
    .mem_din    (mem_din),
    .mem_mask   (mem_mask),
    .mem_rd_ack (mem_rd_ack),
    .mem_wr_ack (mem_wr_ack),
    .mem_dout   (mem_dout)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the cache stopped answering",
             WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "simulation timed out");
  end

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected=%08h actual=%08h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic logic [`HOST_ADDR_BITS-1:0] page_addr(input int page, input int offset);
    return {page[`PAGE_BITS-1:0], offset[`PAGE_WORDS_LOG2-1:0]};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) old_word[8*b +: 8] = new_word[8*b +: 8];
    end
    return old_word;
  endfunction

  // low half at the even halfword
  function automatic logic [31:0] model_word(input logic [15:0] idx);
    return {i_sdram_model.mem[{idx, 1'b1}], i_sdram_model.mem[{idx, 1'b0}]};
  endfunction

  task automatic preload_memory();
    logic [31:0] r;
    for (int i = 0; i < SHADOW_WORDS; i++) begin
      r = $random(seed);
      shadow[i[15:0]] = r;
      i_sdram_model.mem[{i[15:0], 1'b0}] <= r[15:0];
      i_sdram_model.mem[{i[15:0], 1'b1}] <= r[31:16];
    end
  endtask

  task automatic wait_ready(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (waitrequest) begin
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic read_word(input logic [`HOST_ADDR_BITS-1:0] addr, output logic [31:0] data,
                           output int cycles);
    @(posedge clk);
    host.read  <= 1'b1;
    host.write <= 1'b0;
    host.addr  <= addr;
    wait_ready(cycles);
    data = readdata;
    @(posedge clk);
    host.read <= 1'b0;
  endtask

  task automatic write_word(input logic [`HOST_ADDR_BITS-1:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output int cycles);
    @(posedge clk);
    host.write   <= 1'b1;
    host.read    <= 1'b0;
    host.addr    <= addr;
    host.wdata   <= data;
    host.byte_en <= be;
    wait_ready(cycles);
    @(posedge clk);
    host.write <= 1'b0;
  endtask

  // written-back words must now be in memory
  task automatic expect_writeback(input string name);
    foreach (dirty_idx[i]) begin
      check_equal(name, dirty_data[i], model_word(dirty_idx[i]));
      shadow[dirty_idx[i]] = dirty_data[i];
    end
    dirty_idx.delete();
    dirty_data.delete();
  endtask

  task automatic read_miss_then_hit();
    logic [`HOST_ADDR_BITS-1:0] a;
    logic [31:0]                d;
    int                         w;
    a = page_addr(1, 5);
    read_word(a, d, w);
    check_equal("read_miss_data", shadow[a[15:0]], d);
    a = page_addr(1, 9);
    read_word(a, d, w);
    check_equal("read_hit_data", shadow[a[15:0]], d);
    check_equal("read_hit_wait", 32'd1, w);
  endtask

  task automatic write_hit_merge();
    logic [`HOST_ADDR_BITS-1:0] a;
    logic [31:0]                d;
    logic [31:0]                merged;
    int                         w;
    a      = page_addr(1, 9);
    merged = merge_bytes(shadow[a[15:0]], 32'ha5c3_1e7b, 4'b0101);
    write_word(a, 32'ha5c3_1e7b, 4'b0101, w);
    check_equal("write_hit_wait", 32'd1, w);
    dirty_idx.push_back(a[15:0]);
    dirty_data.push_back(merged);
    read_word(a, d, w);
    check_equal("write_hit_readback", merged, d);
    check_equal("write_hit_mem_untouched", shadow[a[15:0]], model_word(a[15:0]));
  endtask

  task automatic write_miss_direct();
    logic [`HOST_ADDR_BITS-1:0] a;
    logic [31:0]                d;
    int                         w;
    a = page_addr(2, 3);
    write_word(a, 32'h3c5a_96f0, 4'b1001, w);
    shadow[a[15:0]] = merge_bytes(shadow[a[15:0]], 32'h3c5a_96f0, 4'b1001);
    check_equal("write_miss_mem", shadow[a[15:0]], model_word(a[15:0]));
    read_word(a, d, w);                     // allocates page 2
    check_equal("write_miss_readback", shadow[a[15:0]], d);
  endtask

  task automatic page_flush();
    logic [`HOST_ADDR_BITS-1:0] a;
    logic [31:0]                d;
    int                         w;
    a = page_addr(1, 20);
    write_word(a, 32'h0f1e_2d3c, 4'b1111, w);
    dirty_idx.push_back(a[15:0]);
    dirty_data.push_back(32'h0f1e_2d3c);
    @(posedge clk);
    flush_valid <= 1'b1;
    flush_page  <= 15'd1;
    read_word(page_addr(1, 0), d, w);
    @(posedge clk);
    flush_valid <= 1'b0;
    expect_writeback("flush_writeback");
    read_word(a, d, w);                     // slot was invalidated so this refills
    check_equal("flush_refill", shadow[a[15:0]], d);
  endtask

  task automatic evict_with_writeback();
    logic [`HOST_ADDR_BITS-1:0] a;
    logic [31:0]                d;
    int                         w;
    for (int p = 3; p <= 16; p++) begin   // pages 1 and 2 already hold slots 0 and 1
      a = page_addr(p, p);
      read_word(a, d, w);
      check_equal("evict_fill", shadow[a[15:0]], d);
    end
    a = page_addr(1, 30);
    write_word(a, 32'h7788_99aa, 4'b1111, w);   // dirty slot 0
    dirty_idx.push_back(a[15:0]);
    dirty_data.push_back(32'h7788_99aa);
    for (int k = 0; k < `LIFE_FILL; k++) begin   // each uncached read decays every life
      a = page_addr(40, k);
      read_word(a, d, w);
      check_equal("evict_uncached", shadow[a[15:0]], d);
    end
    a = page_addr(41, 7);
    read_word(a, d, w);
    expect_writeback("evict_writeback");
    check_equal("evict_new_page", shadow[a[15:0]], d);
  endtask

  initial begin
    seed        = 32'h9e1bb38f;
    sys_rst_n   <= 1'b0;
    host        <= '0;
    flush_valid <= 1'b0;
    flush_page  <= '0;
    preload_memory();
    repeat (3) @(posedge clk);
    sys_rst_n <= 1'b1;
    read_miss_then_hit();
    write_hit_merge();
    write_miss_direct();
    page_flush();
    evict_with_writeback();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_slot.sv
verilog/slot_select.sv
verilog/cache_ctrl.sv
verilog/mem_sequencer.sv
verilog/page_cache_top.sv
sim/sdram_model.sv
sim/tb_page_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_page_cache
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
